// ==== verilog/rtr_macros.svh ====
// size macros of the mesh router, included by the package, the RTL and the testbench
`ifndef RTR_MACROS_SVH
`define RTR_MACROS_SVH

// ------------------------------
// topology
// ------------------------------
// local, west, east, south, north
`define RTR_NUM_PORTS 5
// one coordinate, 4x4 mesh
`define RTR_DIM_ADDR_WIDTH 2
// router address is x then y
`define RTR_ADDR_WIDTH (2 * `RTR_DIM_ADDR_WIDTH)

// ------------------------------
// flit and buffering
// ------------------------------
`define RTR_PAYLOAD_WIDTH 24
`define RTR_FLIT_WIDTH (`RTR_ADDR_WIDTH + `RTR_PAYLOAD_WIDTH)
// input buffer slots, also the initial credit count
`define RTR_BUFFER_DEPTH 4
// credit and occupancy counters must hold the full depth
`define RTR_CREDIT_WIDTH 3

`endif

// ==== verilog/rtr_pkg.sv ====
// flit and port index types of the mesh router, imported by the RTL modules and the testbench
`include "rtr_macros.svh"

package rtr_pkg;

   // port index, also the position in every per-port array
   typedef enum logic [2:0]
   {
      port_local = 3'd0,
      port_west  = 3'd1,
      port_east  = 3'd2,
      port_south = 3'd3,
      port_north = 3'd4
   } port_t;

   // header view of a flit, destination first
   typedef struct packed
   {
      logic [`RTR_DIM_ADDR_WIDTH-1:0] dest_x;
      logic [`RTR_DIM_ADDR_WIDTH-1:0] dest_y;
      logic [`RTR_PAYLOAD_WIDTH-1:0]  payload;
   } flit_header_t;

   // raw word for buffer and crossbar, header view for routing
   typedef union packed
   {
      logic [`RTR_FLIT_WIDTH-1:0] raw;
      flit_header_t               hdr;
   } flit_t;

endpackage

// ==== verilog/rtr_ip_ctrl.sv ====
// input port controller with flit buffer, DOR route and credit return, one per router port
`timescale 1ns/10ps
`include "rtr_macros.svh"

module rtr_ip_ctrl
  (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`RTR_ADDR_WIDTH-1:0] router_address,
   input  logic                       channel_in_valid,
   input  rtr_pkg::flit_t             channel_in_flit,
   input  logic                       flit_sent,
   output logic                       req,
   output rtr_pkg::port_t             route,
   output rtr_pkg::flit_t             head_flit,
   output logic                       flow_ctrl_out,
   output logic                       error
   );

   import rtr_pkg::*;

   localparam int ptr_width = $clog2(`RTR_BUFFER_DEPTH);
   localparam logic [ptr_width-1:0] last_slot = ptr_width'(`RTR_BUFFER_DEPTH - 1);
   localparam logic [`RTR_CREDIT_WIDTH-1:0] depth = `RTR_CREDIT_WIDTH'(`RTR_BUFFER_DEPTH);

   flit_t                          buf_mem [`RTR_BUFFER_DEPTH];
   logic [ptr_width-1:0]           wr_ptr;
   logic [ptr_width-1:0]           rd_ptr;
   logic [`RTR_CREDIT_WIDTH-1:0]   count;
   logic                           full;
   logic                           wr_en;
   logic [`RTR_DIM_ADDR_WIDTH-1:0] cur_x;
   logic [`RTR_DIM_ADDR_WIDTH-1:0] cur_y;

   // ------------------------------
   // flit buffer
   // ------------------------------
   assign full  = (count == depth);
   // a flit arriving on a full buffer is dropped and flagged
   assign wr_en = channel_in_valid && !full;
   assign error = channel_in_valid && full;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
         if (flit_sent)
            rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, flit_sent})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         buf_mem[wr_ptr] <= channel_in_flit;
   end

   // oldest flit is presented to the allocator and crossbar
   assign head_flit = buf_mem[rd_ptr];
   assign req       = (count != '0);

   // ------------------------------
   // route computation, x then y
   // ------------------------------
   assign cur_x = router_address[`RTR_ADDR_WIDTH-1 -: `RTR_DIM_ADDR_WIDTH];
   assign cur_y = router_address[`RTR_DIM_ADDR_WIDTH-1:0];

   always_comb
   begin
      if (head_flit.hdr.dest_x > cur_x)
         route = port_east;
      else if (head_flit.hdr.dest_x < cur_x)
         route = port_west;
      else if (head_flit.hdr.dest_y > cur_y)
         route = port_north;
      else if (head_flit.hdr.dest_y < cur_y)
         route = port_south;
      else
         route = port_local;
   end

   // slot frees as the head leaves, one credit back upstream
   assign flow_ctrl_out = flit_sent;

   // allocator only sends from a non-empty buffer
   assert property (@(posedge clk) disable iff (reset) flit_sent |-> req);

   // occupancy never passes the buffer depth
   assert property (@(posedge clk) disable iff (reset) count <= depth);

endmodule

// ==== verilog/rtr_sw_alloc.sv ====
// switch allocator with one round-robin arbiter per output, gated by downstream credits
`timescale 1ns/10ps
`include "rtr_macros.svh"

module rtr_sw_alloc
  (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic [`RTR_NUM_PORTS-1:0]                     req,
   input  rtr_pkg::port_t [`RTR_NUM_PORTS-1:0]           route,
   input  logic [`RTR_NUM_PORTS-1:0]                     credit_avail,
   output logic [`RTR_NUM_PORTS-1:0][`RTR_NUM_PORTS-1:0] grant,
   output logic [`RTR_NUM_PORTS-1:0]                     flit_sent
   );

   import rtr_pkg::*;

   localparam int num_ports = `RTR_NUM_PORTS;

   genvar op;
   generate
      for (op = 0; op < num_ports; op++)
      begin : g_op
         logic [num_ports-1:0] req_vec;
         logic [num_ports-1:0] gnt;
         port_t                ptr;
         port_t                next_ptr;

         // inputs whose head flit wants this output, only while a credit is held
         always_comb
         begin
            for (int ip = 0; ip < num_ports; ip++)
               req_vec[ip] = req[ip] && (route[ip] == port_t'(op)) && credit_avail[op];
         end

         // first requester at or after the pointer wins
         always_comb
         begin
            logic found;
            int   idx;
            found    = 1'b0;
            gnt      = '0;
            next_ptr = ptr;
            for (int k = 0; k < num_ports; k++)
            begin
               idx = (int'(ptr) + k) % num_ports;
               if (!found && req_vec[idx])
               begin
                  found    = 1'b1;
                  gnt[idx] = 1'b1;
                  next_ptr = (idx == num_ports - 1) ? port_local : port_t'(idx + 1);
               end
            end
         end

         // pointer moves past the winner, stays put when idle
         always_ff @(posedge clk)
         begin
            if (reset)
               ptr <= port_local;
            else
               ptr <= next_ptr;
         end

         assign grant[op] = gnt;

         assert property (@(posedge clk) disable iff (reset) $onehot0(gnt));
      end
   endgenerate

   // each input routes to one output, so no input-side arbitration
   always_comb
   begin
      flit_sent = '0;
      for (int o = 0; o < num_ports; o++)
         flit_sent = flit_sent | grant[o];
   end

endmodule

// ==== verilog/rtr_op_ctrl.sv ====
// output port controller with crossbar column, output register and credit counter, one per port
`timescale 1ns/10ps
`include "rtr_macros.svh"

module rtr_op_ctrl
  (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [`RTR_NUM_PORTS-1:0]           grant,
   input  rtr_pkg::flit_t [`RTR_NUM_PORTS-1:0] in_flits,
   input  logic                                flow_ctrl_in,
   output logic                                channel_out_valid,
   output rtr_pkg::flit_t                      channel_out_flit,
   output logic                                credit_avail,
   output logic                                error
   );

   import rtr_pkg::*;

   localparam logic [`RTR_CREDIT_WIDTH-1:0] credit_max =
      `RTR_CREDIT_WIDTH'(`RTR_BUFFER_DEPTH);

   flit_t                        sel_flit;
   logic                         send;
   logic                         credit_in;
   logic [`RTR_CREDIT_WIDTH-1:0] credits;

   // ------------------------------
   // crossbar column
   // ------------------------------
   // and-or select, grant is one-hot or zero
   always_comb
   begin
      sel_flit.raw = '0;
      for (int ip = 0; ip < `RTR_NUM_PORTS; ip++)
      begin
         if (grant[ip])
            sel_flit.raw = sel_flit.raw | in_flits[ip].raw;
      end
   end

   assign send = |grant;

   always_ff @(posedge clk)
   begin
      if (reset)
         channel_out_valid <= 1'b0;
      else
         channel_out_valid <= send;
   end

   always_ff @(posedge clk)
   begin
      if (send)
         channel_out_flit <= sel_flit;
   end

   // ------------------------------
   // downstream credits
   // ------------------------------
   // downstream never has more free slots than its depth
   assign error     = flow_ctrl_in && (credits == credit_max);
   assign credit_in = flow_ctrl_in && !error;

   always_ff @(posedge clk)
   begin
      if (reset)
         credits <= credit_max;
      else
      begin
         case ({send, credit_in})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   assign credit_avail = (credits != '0);

   // allocator never sends on an output without a credit
   assert property (@(posedge clk) disable iff (reset) send |-> (credits != '0));

endmodule

// ==== verilog/rtr_top.sv ====
// top level of the five-port mesh router, wires the port controllers and the allocator
`timescale 1ns/10ps
`include "rtr_macros.svh"

module rtr_top
  (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [`RTR_ADDR_WIDTH-1:0]          router_address,
   input  logic [`RTR_NUM_PORTS-1:0]           channel_in_valid,
   input  rtr_pkg::flit_t [`RTR_NUM_PORTS-1:0] channel_in_flit,
   output logic [`RTR_NUM_PORTS-1:0]           flow_ctrl_out,
   output logic [`RTR_NUM_PORTS-1:0]           channel_out_valid,
   output rtr_pkg::flit_t [`RTR_NUM_PORTS-1:0] channel_out_flit,
   input  logic [`RTR_NUM_PORTS-1:0]           flow_ctrl_in,
   output logic                                error
   );

   import rtr_pkg::*;

   logic  [`RTR_NUM_PORTS-1:0]                     ipc_req;
   port_t [`RTR_NUM_PORTS-1:0]                     ipc_route;
   flit_t [`RTR_NUM_PORTS-1:0]                     ipc_head_flit;
   logic  [`RTR_NUM_PORTS-1:0]                     ipc_error;
   logic  [`RTR_NUM_PORTS-1:0][`RTR_NUM_PORTS-1:0] alo_grant;
   logic  [`RTR_NUM_PORTS-1:0]                     alo_flit_sent;
   logic  [`RTR_NUM_PORTS-1:0]                     opc_credit_avail;
   logic  [`RTR_NUM_PORTS-1:0]                     opc_error;

   genvar ip;
   genvar op;

   // ------------------------------
   // input ports
   // ------------------------------
   generate
      for (ip = 0; ip < `RTR_NUM_PORTS; ip++)
      begin : g_ip
         rtr_ip_ctrl ipc
           (.clk(clk), .reset(reset), .router_address(router_address),
            .channel_in_valid(channel_in_valid[ip]), .channel_in_flit(channel_in_flit[ip]),
            .flit_sent(alo_flit_sent[ip]), .req(ipc_req[ip]), .route(ipc_route[ip]),
            .head_flit(ipc_head_flit[ip]), .flow_ctrl_out(flow_ctrl_out[ip]),
            .error(ipc_error[ip]));
      end
   endgenerate

   rtr_sw_alloc alo
     (.clk(clk), .reset(reset), .req(ipc_req), .route(ipc_route),
      .credit_avail(opc_credit_avail), .grant(alo_grant), .flit_sent(alo_flit_sent));

   // ------------------------------
   // output ports
   // ------------------------------
   generate
      for (op = 0; op < `RTR_NUM_PORTS; op++)
      begin : g_op
         // every column sees all head flits
         rtr_op_ctrl opc
           (.clk(clk), .reset(reset), .grant(alo_grant[op]), .in_flits(ipc_head_flit),
            .flow_ctrl_in(flow_ctrl_in[op]), .channel_out_valid(channel_out_valid[op]),
            .channel_out_flit(channel_out_flit[op]), .credit_avail(opc_credit_avail[op]),
            .error(opc_error[op]));
      end
   endgenerate

   // sticky until reset, any port controller can set it
   always_ff @(posedge clk)
   begin
      if (reset)
         error <= 1'b0;
      else if (|{ipc_error, opc_error})
         error <= 1'b1;
   end

endmodule

// ==== testbench/tb_clock.sv ====
// clock and power-on reset source for the router testbench, instantiated once in rtr_tb
`timescale 1ns/10ps

module tb_clock
  (
   output logic clk,
   output logic reset
   );

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // reset held for the first 4 rising edges
   initial
   begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== testbench/rtr_tb.sv ====
// testbench for rtr_top, drives random and directed traffic and checks it with assertions
`timescale 1ns/10ps
`include "rtr_macros.svh"

module rtr_tb;

   import rtr_pkg::*;

   localparam int np = `RTR_NUM_PORTS;
   localparam int depth = `RTR_BUFFER_DEPTH;
   localparam int random_cycles = 400;
   localparam int hold_cycles = 150;
   // traffic phases plus drains and error phases, with margin
   localparam int watchdog_cycles = 5 * (random_cycles + hold_cycles) + 250;
   localparam logic [1:0] self_x = 2'd1;
   localparam logic [1:0] self_y = 2'd2;

   logic clk;
   logic por_reset;
   logic tb_reset = 1'b0;
   logic reset;
   logic [`RTR_ADDR_WIDTH-1:0] router_address;
   logic [np-1:0] channel_in_valid = '0;
   flit_t [np-1:0] channel_in_flit = '0;
   logic [np-1:0] flow_ctrl_out;
   logic [np-1:0] channel_out_valid;
   flit_t [np-1:0] channel_out_flit;
   logic [np-1:0] flow_ctrl_in = '0;
   logic error;

   // ------------------------------
   // model state
   // ------------------------------
   // upstream credits, downstream credits owed, scoreboard counts
   int up_credit [np];
   int owed [np];
   int inj_cnt [np][np];
   int rcv_cnt [np][np];
   int inj_tot [np];
   int fc_cnt [np];
   int east_held_sent = 0;
   int quiet_cycles = 0;
   logic [np-1:0] vin_next;
   flit_t [np-1:0] fin_next;

   // phase controls, written by the sequencer with NBAs
   logic traffic_on = 1'b0;
   logic hold_east = 1'b0;
   logic fill_local = 1'b0;
   logic lone_req = 1'b0;
   logic ovf_req = 1'b0;
   logic surplus_req = 1'b0;
   logic drain_chk = 1'b0;
   logic err_armed = 1'b0;
   // one-shot markers for the timed checks
   logic lone_inj = 1'b0;
   logic lone_d1 = 1'b0;
   logic ovf_inj = 1'b0;
   logic surplus_inj = 1'b0;

   tb_clock clkgen (.clk(clk), .reset(por_reset));

   assign reset = por_reset | tb_reset;
   assign router_address = {self_x, self_y};

   rtr_top uut
     (.clk(clk), .reset(reset), .router_address(router_address),
      .channel_in_valid(channel_in_valid), .channel_in_flit(channel_in_flit),
      .flow_ctrl_out(flow_ctrl_out), .channel_out_valid(channel_out_valid),
      .channel_out_flit(channel_out_flit), .flow_ctrl_in(flow_ctrl_in), .error(error));

   // x first, then y, equal address stays local
   function automatic port_t expected_port(input logic [1:0] dx, input logic [1:0] dy);
      if (dx > self_x)
         return port_east;
      if (dx < self_x)
         return port_west;
      if (dy > self_y)
         return port_north;
      if (dy < self_y)
         return port_south;
      return port_local;
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // payload is source port, spare bits, then sequence number per source and output
   task automatic send_flit(input int ip, input logic [1:0] dx, input logic [1:0] dy);
      int op;
      op = int'(expected_port(dx, dy));
      vin_next[ip] = 1'b1;
      fin_next[ip].hdr.dest_x = dx;
      fin_next[ip].hdr.dest_y = dy;
      fin_next[ip].hdr.payload = {3'(ip), 3'b000, 18'(inj_cnt[ip][op])};
      inj_cnt[ip][op]++;
      inj_tot[ip]++;
      up_credit[ip]--;
   endtask

   task automatic wait_quiet();
      repeat (2) @(posedge clk);
      while (quiet_cycles < 20)
         @(posedge clk);
   endtask

   // ------------------------------
   // traffic engine
   // ------------------------------
   always @(posedge clk)
   begin
      logic [np-1:0] fci_next;
      logic busy;
      int src;
      vin_next = '0;
      fin_next = channel_in_flit;
      fci_next = '0;
      busy = 1'b0;
      lone_inj <= 1'b0;
      ovf_inj <= 1'b0;
      surplus_inj <= 1'b0;
      lone_d1 <= lone_inj;
      if (reset)
      begin
         for (int p = 0; p < np; p++)
         begin
            up_credit[p] = depth;
            owed[p] = 0;
         end
         quiet_cycles = 0;
      end
      else
      begin
         if (!hold_east)
            east_held_sent = 0;
         // downstream side, credits go back after a random delay
         for (int op = 0; op < np; op++)
         begin
            if (channel_out_valid[op])
            begin
               src = int'(channel_out_flit[op].hdr.payload[23:21]);
               if (src < np)
                  rcv_cnt[src][op]++;
               owed[op]++;
               busy = 1'b1;
               if (hold_east && op == int'(port_east))
                  east_held_sent++;
            end
            if (owed[op] > 0 && !(hold_east && op == int'(port_east)))
            begin
               busy = 1'b1;
               if ($urandom_range(1, 0) == 1)
               begin
                  fci_next[op] = 1'b1;
                  owed[op]--;
               end
            end
         end
         // upstream side
         for (int ip = 0; ip < np; ip++)
         begin
            if (flow_ctrl_out[ip])
            begin
               up_credit[ip]++;
               fc_cnt[ip]++;
               busy = 1'b1;
            end
            if (traffic_on && up_credit[ip] > 0 && $urandom_range(1, 0) == 1)
               send_flit(ip, 2'($urandom_range(3, 0)), 2'($urandom_range(3, 0)));
         end
         // east-bound fill of the local buffer
         if (fill_local && up_credit[int'(port_local)] > 0)
            send_flit(int'(port_local), 2'd3, self_y);
         // lone flit into west, bound south
         if (lone_req)
         begin
            send_flit(int'(port_west), 2'd1, 2'd0);
            lone_inj <= 1'b1;
         end
         // no credit left here, this one overflows
         if (ovf_req)
         begin
            vin_next[int'(port_local)] = 1'b1;
            fin_next[int'(port_local)].raw = '1;
            ovf_inj <= 1'b1;
         end
         if (surplus_req)
         begin
            fci_next[int'(port_north)] = 1'b1;
            surplus_inj <= 1'b1;
         end
         if (vin_next != '0)
            busy = 1'b1;
         quiet_cycles = busy ? 0 : quiet_cycles + 1;
      end
      channel_in_valid <= vin_next;
      channel_in_flit <= fin_next;
      flow_ctrl_in <= fci_next;
   end

   // ------------------------------
   // sequencer
   // ------------------------------
   initial
   begin
      void'($urandom(13));
      while (reset)
         @(posedge clk);
      // random traffic on all inputs
      traffic_on <= 1'b1;
      repeat (random_cycles) @(posedge clk);
      traffic_on <= 1'b0;
      wait_quiet();
      drain_chk <= 1'b1;
      @(posedge clk);
      drain_chk <= 1'b0;
      // lone flit into an idle router
      lone_req <= 1'b1;
      @(posedge clk);
      lone_req <= 1'b0;
      wait_quiet();
      // traffic while east credits are withheld, then released
      hold_east <= 1'b1;
      traffic_on <= 1'b1;
      repeat (hold_cycles) @(posedge clk);
      traffic_on <= 1'b0;
      repeat (20) @(posedge clk);
      hold_east <= 1'b0;
      wait_quiet();
      drain_chk <= 1'b1;
      @(posedge clk);
      drain_chk <= 1'b0;
      // fill local and east until the local buffer is full
      hold_east <= 1'b1;
      fill_local <= 1'b1;
      wait_quiet();
      fill_local <= 1'b0;
      err_armed <= 1'b1;
      ovf_req <= 1'b1;
      @(posedge clk);
      ovf_req <= 1'b0;
      repeat (10) @(posedge clk);
      // reset, then one credit too many on north
      hold_east <= 1'b0;
      tb_reset <= 1'b1;
      repeat (4) @(posedge clk);
      tb_reset <= 1'b0;
      repeat (3) @(posedge clk);
      surplus_req <= 1'b1;
      @(posedge clk);
      surplus_req <= 1'b0;
      repeat (10) @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: the run did not end within %0d cycles", watchdog_cycles);
      abort_run();
   end

   // ------------------------------
   // checks
   // ------------------------------
   assert property (@(posedge clk)
                    reset |=> (channel_out_valid == '0 && flow_ctrl_out == '0 && !error))
   else
   begin
      $display("MISMATCH reset: expected 0, actual valid %b credit %b error %b",
               $sampled(channel_out_valid), $sampled(flow_ctrl_out), $sampled(error));
      abort_run();
   end

   genvar op;
   genvar ip;
   generate
      for (op = 0; op < np; op++)
      begin : g_out
         logic [2:0]  src;
         logic [17:0] seq;
         port_t       exp_port;
         int          exp_seq;
         int          inj_from;

         assign src = channel_out_flit[op].hdr.payload[23:21];
         assign seq = channel_out_flit[op].hdr.payload[17:0];
         assign exp_port = expected_port(channel_out_flit[op].hdr.dest_x,
                                         channel_out_flit[op].hdr.dest_y);
         assign exp_seq = (int'(src) < np) ? rcv_cnt[src][op] : 0;
         assign inj_from = (int'(src) < np) ? inj_cnt[src][op] : 0;

         assert property (@(posedge clk) disable iff (reset)
                          channel_out_valid[op] |-> exp_port == port_t'(op))
         else
         begin
            $display("MISMATCH routing: expected port %0d, actual port %0d",
                     $sampled(exp_port), op);
            abort_run();
         end

         assert property (@(posedge clk) disable iff (reset)
                          channel_out_valid[op] |-> int'(src) < np)
         else
         begin
            $display("port %0d sent a payload that was never injected", op);
            abort_run();
         end

         // order per input and output pair
         assert property (@(posedge clk) disable iff (reset)
                          channel_out_valid[op] |-> int'(seq) == exp_seq)
         else
         begin
            $display("MISMATCH ordering: expected %0d, actual %0d",
                     $sampled(exp_seq), $sampled(seq));
            abort_run();
         end

         assert property (@(posedge clk) disable iff (reset)
                          channel_out_valid[op] |-> exp_seq < inj_from)
         else
         begin
            $display("port %0d sent a flit more often than it was injected", op);
            abort_run();
         end

         for (ip = 0; ip < np; ip++)
         begin : g_pair
            assert property (@(posedge clk) drain_chk |-> rcv_cnt[ip][op] == inj_cnt[ip][op])
            else
            begin
               $display("MISMATCH delivery: expected %0d, actual %0d",
                        $sampled(inj_cnt[ip][op]), $sampled(rcv_cnt[ip][op]));
               abort_run();
            end
         end

         assert property (@(posedge clk) drain_chk |-> fc_cnt[op] == inj_tot[op])
         else
         begin
            $display("MISMATCH credit_return: expected %0d, actual %0d",
                     $sampled(inj_tot[op]), $sampled(fc_cnt[op]));
            abort_run();
         end
      end
   endgenerate

   // lone flit leaves south on the edge after it is buffered, not before
   assert property (@(posedge clk) lone_d1 |-> !channel_out_valid[port_south])
   else
   begin
      $display("idle latency: the lone flit left south too early");
      abort_run();
   end

   assert property (@(posedge clk) lone_d1 |=> channel_out_valid[port_south])
   else
   begin
      $display("idle latency: the lone flit did not leave south on time");
      abort_run();
   end

   assert property (@(posedge clk) east_held_sent <= depth)
   else
   begin
      $display("back-pressure: %0d flits left east without credits", $sampled(east_held_sent));
      abort_run();
   end

   assert property (@(posedge clk) disable iff (reset) ovf_inj |=> error)
   else
   begin
      $display("error flag did not rise after the input buffer overflowed");
      abort_run();
   end

   assert property (@(posedge clk) disable iff (reset) surplus_inj |=> error)
   else
   begin
      $display("error flag did not rise after a surplus credit");
      abort_run();
   end

   // sticky until reset
   assert property (@(posedge clk) disable iff (reset) error |=> error)
   else
   begin
      $display("error flag dropped without a reset");
      abort_run();
   end

   assert property (@(posedge clk) disable iff (reset) !err_armed |-> !error)
   else
   begin
      $display("error flag rose during legal traffic");
      abort_run();
   end

endmodule

// ==== rtr_top.f ====
+incdir+verilog
verilog/rtr_pkg.sv
verilog/rtr_ip_ctrl.sv
verilog/rtr_sw_alloc.sv
verilog/rtr_op_ctrl.sv
verilog/rtr_top.sv
testbench/tb_clock.sv
testbench/rtr_tb.sv

// ==== Makefile ====
# Verilator build for the mesh router and its testbench

TOOL     = verilator
FLAGS    = --assert --timing
TB_TOP   = rtr_tb
RTL_TOP  = rtr_top
FILELIST = rtr_top.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

# lint the RTL top level on its own
lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build and run, the exit status of the run is the result
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
